// ==== common/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

	parameter int DATA_W = 32;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [4:0] shamt_t;

	// operation code, no decoder in this unit
	typedef logic [4:0] alu_func_t;

	localparam alu_func_t ALU_ADD   = 5'd0;
	localparam alu_func_t ALU_ADDU  = 5'd1;
	localparam alu_func_t ALU_SUB   = 5'd2;
	localparam alu_func_t ALU_SUBU  = 5'd3;
	localparam alu_func_t ALU_AND   = 5'd4;
	localparam alu_func_t ALU_OR    = 5'd5;
	localparam alu_func_t ALU_XOR   = 5'd6;
	localparam alu_func_t ALU_NOR   = 5'd7;
	localparam alu_func_t ALU_SLT   = 5'd8;
	localparam alu_func_t ALU_SLTU  = 5'd9;
	localparam alu_func_t ALU_SLL   = 5'd10;
	localparam alu_func_t ALU_SRL   = 5'd11;
	localparam alu_func_t ALU_SRA   = 5'd12;
	localparam alu_func_t ALU_MULT  = 5'd13;
	localparam alu_func_t ALU_MULTU = 5'd14;
	localparam alu_func_t ALU_DIV   = 5'd15;
	localparam alu_func_t ALU_DIVU  = 5'd16;
	localparam alu_func_t ALU_MFHI  = 5'd17;
	localparam alu_func_t ALU_MFLO  = 5'd18;
	localparam alu_func_t ALU_MTHI  = 5'd19;
	localparam alu_func_t ALU_MTLO  = 5'd20;

	typedef struct packed {
		logic overflow; // signed add/sub only
		logic zero;     // result word is zero
	} alu_status_t;

	typedef struct packed {
		alu_func_t func;
		data_t     data1;
		data_t     data2;
	} alu_req_t;

	typedef struct packed {
		data_t       result;
		alu_status_t status;
	} alu_resp_t;

endpackage

`default_nettype wire

// ==== alu/alu_core.sv ====
`default_nettype none

module alu_core #(
	parameter int DATA_W = 32
) (
	input  alu_pkg::alu_func_t   func,
	input  alu_pkg::data_t       data1,
	input  alu_pkg::data_t       data2,
	input  alu_pkg::data_t       reg_hi,
	input  alu_pkg::data_t       reg_lo,
	output alu_pkg::data_t       res_hi,
	output alu_pkg::data_t       res_lo,
	output alu_pkg::alu_status_t status
);
	import alu_pkg::*;

	shamt_t              shamt;
	data_t               sum;
	data_t               diff;
	logic                add_ovf;
	logic                sub_ovf;
	logic [2*DATA_W-1:0] prod_s;
	logic [2*DATA_W-1:0] prod_u;
	logic                div_zero;
	data_t               divisor;
	data_t               quot_s;
	data_t               rem_s;
	data_t               quot_u;
	data_t               rem_u;

	assign shamt = data1[4:0]; // variable shifts, amount from data1

	assign sum  = data1 + data2;
	assign diff = data1 - data2;

	// same signs in, different sign out
	assign add_ovf = (data1[DATA_W-1] == data2[DATA_W-1]) &&
		(sum[DATA_W-1] != data1[DATA_W-1]);
	assign sub_ovf = (data1[DATA_W-1] != data2[DATA_W-1]) &&
		(diff[DATA_W-1] != data1[DATA_W-1]);

	assign prod_s = $signed({{DATA_W{data1[DATA_W-1]}}, data1}) *
		$signed({{DATA_W{data2[DATA_W-1]}}, data2});
	assign prod_u = {{DATA_W{1'b0}}, data1} * {{DATA_W{1'b0}}, data2};

	// keep the dividers away from zero, the result is replaced below
	assign div_zero = (data2 == '0);
	assign divisor  = div_zero ? data_t'(1) : data2;
	assign quot_s   = data_t'($signed(data1) / $signed(divisor));
	assign rem_s    = data_t'($signed(data1) % $signed(divisor));
	assign quot_u   = data1 / divisor;
	assign rem_u    = data1 % divisor;

	always_comb begin
		res_hi = reg_hi; // hi untouched unless stated
		res_lo = '0;
		case (func)
			ALU_ADD, ALU_ADDU: res_lo = sum;
			ALU_SUB, ALU_SUBU: res_lo = diff;
			ALU_AND:  res_lo = data1 & data2;
			ALU_OR:   res_lo = data1 | data2;
			ALU_XOR:  res_lo = data1 ^ data2;
			ALU_NOR:  res_lo = ~(data1 | data2);
			ALU_SLT:  res_lo = data_t'($signed(data1) < $signed(data2));
			ALU_SLTU: res_lo = data_t'(data1 < data2);
			ALU_SLL:  res_lo = data2 << shamt;
			ALU_SRL:  res_lo = data2 >> shamt;
			ALU_SRA:  res_lo = data_t'($signed(data2) >>> shamt);
			ALU_MULT: begin
				res_hi = prod_s[2*DATA_W-1:DATA_W];
				res_lo = prod_s[DATA_W-1:0];
			end
			ALU_MULTU: begin
				res_hi = prod_u[2*DATA_W-1:DATA_W];
				res_lo = prod_u[DATA_W-1:0];
			end
			ALU_DIV: begin
				res_hi = div_zero ? data1 : rem_s;
				res_lo = div_zero ? '1 : quot_s;
			end
			ALU_DIVU: begin
				res_hi = div_zero ? data1 : rem_u;
				res_lo = div_zero ? '1 : quot_u;
			end
			ALU_MFHI: res_lo = reg_hi;
			ALU_MFLO: res_lo = reg_lo;
			ALU_MTHI: begin
				res_hi = data1;
				res_lo = reg_lo; // lo written back unchanged
			end
			ALU_MTLO: res_lo = data1;
			default:  res_lo = '0;
		endcase
	end

	assign status = '{
		overflow: ((func == ALU_ADD) && add_ovf) || ((func == ALU_SUB) && sub_ovf),
		zero:     (res_lo == '0)
	};

endmodule

`default_nettype wire

// ==== alu/alu_hilo.sv ====
`default_nettype none

module alu_hilo #(
	parameter int DATA_W = 32
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               head_valid,
	input  alu_pkg::alu_req_t  head_req,
	input  logic               ready,
	output logic               pop,
	output logic               exec_valid,
	output alu_pkg::alu_resp_t exec_resp
);
	import alu_pkg::*;

	data_t       reg_hi;
	data_t       reg_lo;
	data_t       res_hi;
	data_t       res_lo;
	alu_status_t core_status;
	logic        store_hi;
	logic        store_lo;
	logic        exec;

	alu_core #(
		.DATA_W (DATA_W)
	) u_core (
		.func   (head_req.func),
		.data1  (head_req.data1),
		.data2  (head_req.data2),
		.reg_hi (reg_hi),
		.reg_lo (reg_lo),
		.res_hi (res_hi),
		.res_lo (res_lo),
		.status (core_status)
	);

	always_comb begin
		case (head_req.func)
			ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU: {store_hi, store_lo} = 2'b11;
			ALU_MTHI: {store_hi, store_lo} = 2'b10;
			ALU_MTLO: {store_hi, store_lo} = 2'b01;
			default:  {store_hi, store_lo} = 2'b00;
		endcase
	end

	assign exec = head_valid && ready; // one update per request

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			reg_hi <= '0;
			reg_lo <= '0;
		end else if (exec) begin
			if (store_hi)
				reg_hi <= res_hi;
			if (store_lo)
				reg_lo <= res_lo;
		end
	end

	assign pop        = exec;
	assign exec_valid = exec;
	assign exec_resp  = '{result: res_lo, status: core_status};

endmodule

`default_nettype wire

// ==== src/alu_req_fifo.sv ====
`default_nettype none

module alu_req_fifo #(
	parameter int DEPTH = 4
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              in_valid,
	input  alu_pkg::alu_req_t in_req,
	input  logic              pop,
	output logic              in_credit,
	output logic              head_valid,
	output alu_pkg::alu_req_t head_req
);
	import alu_pkg::*;

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	alu_req_t         mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	// sender credits keep this from overflowing
	always_ff @(posedge clk) begin
		if (in_valid)
			mem[wr_ptr] <= in_req;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			in_credit <= 1'b0;
		end else begin
			if (in_valid)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({in_valid, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			in_credit <= pop; // slot freed, give it back
		end
	end

	assign head_valid = (count != '0);
	assign head_req   = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== src/alu_result_stage.sv ====
`default_nettype none

module alu_result_stage #(
	parameter int CREDITS = 2
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               exec_valid,
	input  alu_pkg::alu_resp_t exec_resp,
	input  logic               out_credit,
	output logic               ready,
	output logic               out_valid,
	output alu_pkg::alu_resp_t out_resp
);
	import alu_pkg::*;

	localparam int CNT_W = $clog2(CREDITS + 1);

	alu_resp_t        resp_q;
	logic             full;
	logic [CNT_W-1:0] credits;
	logic             send;

	assign send  = full && (credits != '0);
	assign ready = !full || send; // refill behind a send

	always_ff @(posedge clk) begin
		if (exec_valid && ready)
			resp_q <= exec_resp;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			full    <= 1'b0;
			credits <= CNT_W'(CREDITS);
		end else begin
			if (exec_valid && ready)
				full <= 1'b1;
			else if (send)
				full <= 1'b0;
			case ({out_credit, send})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	assign out_valid = send;
	assign out_resp  = resp_q;

endmodule

`default_nettype wire

// ==== src/alu_pipe_top.sv ====
`default_nettype none

module alu_pipe_top #(
	parameter int DATA_W      = 32,
	parameter int REQ_DEPTH   = 4,
	parameter int OUT_CREDITS = 2
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               in_valid,
	input  alu_pkg::alu_req_t  in_req,
	input  logic               out_credit,
	output logic               in_credit,
	output logic               out_valid,
	output alu_pkg::alu_resp_t out_resp
);
	import alu_pkg::*;

	logic      head_valid;
	alu_req_t  head_req;
	logic      pop;
	logic      exec_valid;
	alu_resp_t exec_resp;
	logic      ready;

	alu_req_fifo #(
		.DEPTH (REQ_DEPTH)
	) u_req_fifo (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_req     (in_req),
		.pop        (pop),
		.in_credit  (in_credit),
		.head_valid (head_valid),
		.head_req   (head_req)
	);

	alu_hilo #(
		.DATA_W (DATA_W)
	) u_hilo (
		.clk        (clk),
		.rst_n      (rst_n),
		.head_valid (head_valid),
		.head_req   (head_req),
		.ready      (ready),
		.pop        (pop),
		.exec_valid (exec_valid),
		.exec_resp  (exec_resp)
	);

	alu_result_stage #(
		.CREDITS (OUT_CREDITS)
	) u_result_stage (
		.clk        (clk),
		.rst_n      (rst_n),
		.exec_valid (exec_valid),
		.exec_resp  (exec_resp),
		.out_credit (out_credit),
		.ready      (ready),
		.out_valid  (out_valid),
		.out_resp   (out_resp)
	);

endmodule

`default_nettype wire

// ==== testbench/alu_pipe_tb.sv ====
`default_nettype none

module alu_pipe_tb;
	import alu_pkg::*;

	localparam int DATA_W      = 32;
	localparam int REQ_DEPTH   = 4;
	localparam int OUT_CREDITS = 2;
	localparam int MAX_RECS    = 64;
	localparam int REC_WORDS   = 5; // func data1 data2 result status

	logic      clk        = 1'b0;
	logic      rst_n      = 1'b0;
	logic      in_valid   = 1'b0;
	alu_req_t  in_req     = '0;
	logic      out_credit = 1'b0;
	logic      in_credit;
	logic      out_valid;
	alu_resp_t out_resp;

	logic [31:0] words [REC_WORDS*MAX_RECS];
	alu_req_t    reqs [MAX_RECS];
	alu_resp_t   expected [MAX_RECS];
	int          num_recs  = 0;
	logic        loaded    = 1'b0;
	logic [31:0] lfsr      = 32'he32a_da95;
	int          rcv_count = 0;
	int          req_credits;
	int          dut_credits;  // mirror of the result stage counter
	int          owed_credits; // results taken but not yet credited
	int          sent;

	alu_pipe_top #(
		.DATA_W      (DATA_W),
		.REQ_DEPTH   (REQ_DEPTH),
		.OUT_CREDITS (OUT_CREDITS)
	) i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_req     (in_req),
		.out_credit (out_credit),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_resp   (out_resp)
	);

	always #50 clk = ~clk;

	// one galois step per bit
	function automatic logic step_lfsr();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b)
			lfsr = lfsr ^ 32'h8020_0003;
		return b;
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int k = 0; k < n; k++)
			v = (v << 1) | int'(step_lfsr());
		return v;
	endfunction

	task automatic load_records();
		int i;
		for (i = 0; i < REC_WORDS*MAX_RECS; i++)
			words[i] = 32'hffff_0000 | i; // upper half set so never a func code
		$readmemh("testbench/alu_input.txt", words);
		i = 0;
		while (i < MAX_RECS && words[REC_WORDS*i] <= 32'h1f) begin
			reqs[i] = '{
				func:  alu_func_t'(words[REC_WORDS*i][4:0]),
				data1: words[REC_WORDS*i+1],
				data2: words[REC_WORDS*i+2]
			};
			expected[i] = '{
				result: words[REC_WORDS*i+3],
				status: alu_status_t'(words[REC_WORDS*i+4][1:0])
			};
			i++;
		end
		num_recs = i;
	endtask

	task automatic check_result();
		assert (rcv_count < num_recs) else begin
			$display("the DUT sent more results than there were requests");
			$display("TEST FAILED");
			$fatal(1);
		end
		assert (out_resp == expected[rcv_count]) else begin
			$display("FAIL time %0t op %0d: got %h status %b, expected %h status %b",
				$time, rcv_count, out_resp.result, out_resp.status,
				expected[rcv_count].result, expected[rcv_count].status);
			$display("TEST FAILED");
			$fatal(1);
		end
		rcv_count++;
	endtask

	// sender and consumer see the values of the cycle just ended
	always @(posedge clk) begin
		if (!rst_n) begin
			req_credits  = REQ_DEPTH;
			dut_credits  = OUT_CREDITS;
			owed_credits = 0;
			sent         = 0;
			in_valid   <= 1'b0;
			out_credit <= 1'b0;
		end else begin
			if (out_valid) begin
				assert (dut_credits > 0) else begin
					$display("out_valid was raised while the DUT held no output credit");
					$display("TEST FAILED");
					$fatal(1);
				end
				check_result();
				dut_credits--;
				owed_credits++;
			end
			if (out_credit)
				dut_credits++;
			if (in_credit)
				req_credits++;
			assert (req_credits <= REQ_DEPTH) else begin
				$display("the DUT returned more request credits than it was given");
				$display("TEST FAILED");
				$fatal(1);
			end
			if (owed_credits > 0 && rand_bits(1) == 1) begin
				out_credit <= 1'b1;
				owed_credits--;
			end else begin
				out_credit <= 1'b0;
			end
			if (sent < num_recs && req_credits > 0 && rand_bits(2) != 0) begin
				in_valid <= 1'b1;
				in_req   <= reqs[sent];
				req_credits--;
				sent++;
			end else begin
				in_valid <= 1'b0;
			end
		end
	end

	initial begin
		load_records();
		assert (num_recs > 0) else begin
			$display("no requests could be read from the data file");
			$display("TEST FAILED");
			$fatal(1);
		end
		loaded = 1'b1;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		wait (rcv_count == num_recs && req_credits == REQ_DEPTH); // request credits home too
		$display("TEST OK");
		$finish;
	end

	initial begin
		wait (loaded);
		repeat (40 * num_recs + 100) @(posedge clk);
		$display("timed out, the DUT did not return all results in time");
		$display("TEST FAILED");
		$fatal(1);
	end

endmodule

`default_nettype wire

// ==== testbench/alu_input.txt ====
// func data1 data2 expected_result expected_status, all hex
// status is {overflow, zero}
11 00000000 00000000 00000000 1
12 00000000 00000000 00000000 1
00 00000005 00000003 00000008 0
00 7fffffff 00000001 80000000 2
01 7fffffff 00000001 80000000 0
00 ffffffff 00000001 00000000 1
02 80000000 00000001 7fffffff 2
03 00000000 00000001 ffffffff 0
04 f0f0f0f0 ff00ff00 f000f000 0
05 f0f0f0f0 0f0f0000 fffff0f0 0
06 aaaaaaaa aaaaaaaa 00000000 1
07 00000000 00000000 ffffffff 0
08 ffffffff 00000001 00000001 0
09 ffffffff 00000001 00000000 1
0a 00000004 00000001 00000010 0
0b 00000004 80000000 08000000 0
0c 00000004 80000000 f8000000 0
0c 0000001f 7fffffff 00000000 1
0a 00000024 00000001 00000010 0
0d ffffffff 00000002 fffffffe 0
11 00000000 00000000 ffffffff 0
12 00000000 00000000 fffffffe 0
0e ffffffff 00000002 fffffffe 0
11 00000000 00000000 00000001 0
0f fffffff9 00000002 fffffffd 0
11 00000000 00000000 ffffffff 0
10 00000007 00000002 00000003 0
11 00000000 00000000 00000001 0
0f 00000009 00000000 ffffffff 0
11 00000000 00000000 00000009 0
10 12345678 00000000 ffffffff 0
11 00000000 00000000 12345678 0
13 0000abcd 00000000 ffffffff 0
11 00000000 00000000 0000abcd 0
12 00000000 00000000 ffffffff 0
14 00001234 00000000 00001234 0
11 00000000 00000000 0000abcd 0
12 00000000 00000000 00001234 0
14 00000000 00000000 00000000 1
12 00000000 00000000 00000000 1

// ==== compile.f ====
common/alu_pkg.sv
alu/alu_core.sv
alu/alu_hilo.sv
src/alu_req_fifo.sv
src/alu_result_stage.sv
src/alu_pipe_top.sv
testbench/alu_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module alu_pipe_tb \
	-f compile.f -o alu_pipe_sim > build.log 2>&1 &&
	./obj_dir/alu_pipe_sim > sim.log 2>&1 ||
	echo "build or simulation exited with an error, see build.log and sim.log"
grep -qs "^TEST OK$" sim.log && echo "simulation passed" && exit 0 ||
	{ echo "simulation failed"; exit 1; }
